// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_tomasulo_core
FILELIST  ?= tomasulo_core.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: include/tomasulo_settings.svh
`ifndef TOMASULO_SETTINGS_SVH
`define TOMASULO_SETTINGS_SVH

`define XLEN       32  // data word width
`define NUM_REGS   32
`define ROB_SIZE   8   // power of two, rob pointers wrap freely
`define RS_DEPTH   3   // entries per station
`define MUL_STAGES 3

`endif

// File: source/alu_unit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
  input  wire                         clk_100mhz,
  input  wire                         sys_rst,
  input  wire                         i_issue,
  input  wire tomasulo_pkg::word_t    i_a, i_b,
  input  wire tomasulo_pkg::alu_op_t  i_op,
  input  wire tomasulo_pkg::rob_idx_t i_tag,
  output logic                        o_accept,
  output logic                        o_result_valid,
  output tomasulo_pkg::word_t         o_result,
  output tomasulo_pkg::rob_idx_t      o_tag,
  input  wire                         i_grant
);
  import tomasulo_pkg::*;

  word_t      res;
  logic [4:0] shamt;

  assign shamt = i_b[4:0];

  always_comb begin
    case (i_op)
      ALU_ADD:  res = i_a + i_b;
      ALU_SUB:  res = i_a - i_b;
      ALU_AND:  res = i_a & i_b;
      ALU_OR:   res = i_a | i_b;
      ALU_XOR:  res = i_a ^ i_b;
      ALU_SLT:  res = word_t'($signed(i_a) < $signed(i_b));
      ALU_SLTU: res = word_t'(i_a < i_b);
      ALU_SLL:  res = i_a << shamt;
      ALU_SRL:  res = i_a >> shamt;
      ALU_SRA:  res = $signed(i_a) >>> shamt;
      default:  res = '0;
    endcase
  end

  // result register frees up in the cycle it is granted
  assign o_accept = !o_result_valid || i_grant;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_result_valid <= 1'b0;
    end else if (i_issue) begin
      o_result_valid <= 1'b1;
    end else if (i_grant) begin
      o_result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_issue) begin
      o_result <= res;
      o_tag    <= i_tag;
    end
  end

endmodule

`default_nettype wire

// File: source/cdb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter (
  input  wire                         clk_100mhz,
  input  wire                         sys_rst,
  input  wire                         i_mul_valid,
  input  wire tomasulo_pkg::word_t    i_mul_result,
  input  wire tomasulo_pkg::rob_idx_t i_mul_tag,
  input  wire                         i_alu_valid,
  input  wire tomasulo_pkg::word_t    i_alu_result,
  input  wire tomasulo_pkg::rob_idx_t i_alu_tag,
  output logic                        o_mul_grant,
  output logic                        o_alu_grant,
  output tomasulo_pkg::cdb_t          o_cdb
);

  // mul wins, its deeper pipe backs up sooner
  assign o_mul_grant = i_mul_valid;
  assign o_alu_grant = i_alu_valid && !i_mul_valid;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_cdb.valid <= 1'b0;
    end else begin
      o_cdb.valid <= i_mul_valid || i_alu_valid;
    end
    if (o_mul_grant) begin
      o_cdb.tag   <= i_mul_tag;
      o_cdb.value <= i_mul_result;
    end else begin
      o_cdb.tag   <= i_alu_tag;
      o_cdb.value <= i_alu_result;
    end
  end

endmodule

`default_nettype wire

// File: source/issue_unit.sv
`timescale 1ns/10ps
`default_nettype none

module issue_unit (
  input  wire                      i_inst_valid,
  input  wire tomasulo_pkg::word_t i_inst,
  output logic                     o_inst_ready,
  output tomasulo_pkg::reg_idx_t   o_rs1, o_rs2,
  input  wire                      i_rf_busy1, i_rf_busy2,
  input  wire tomasulo_pkg::rob_idx_t i_rf_tag1, i_rf_tag2,
  input  wire tomasulo_pkg::word_t i_rf_val1, i_rf_val2,
  input  wire                      i_rob_done1, i_rob_done2,
  input  wire tomasulo_pkg::word_t i_rob_val1, i_rob_val2,
  input  wire                      i_rob_full,
  input  wire tomasulo_pkg::rob_idx_t i_rob_tail,
  output logic                     o_alloc,
  output tomasulo_pkg::reg_idx_t   o_rd,
  input  wire tomasulo_pkg::cdb_t  i_cdb,
  input  wire                      i_alu_free, i_mul_free,
  output logic                     o_alu_push, o_mul_push,
  output tomasulo_pkg::issue_t     o_entry,
  output tomasulo_pkg::alu_op_t    o_alu_op
);
  import tomasulo_pkg::*;

  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;

  typedef enum logic [1:0] {CL_NOP, CL_ALU, CL_MUL} inst_class_t;

  inst_class_t cls;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        alt;  // sub / sra select
  word_t       imm;
  operand_t    opnd_a;
  operand_t    opnd_b;
  logic        accept;

  // regfile, then rob, then the bus this cycle, else wait on the tag
  function automatic operand_t resolve(input logic busy, input rob_idx_t tag,
                                       input word_t rf_val, input logic rob_done,
                                       input word_t rob_val, input cdb_t cdb);
    operand_t op;
    op.tag   = tag;
    op.ready = 1'b1;
    if (!busy) begin
      op.value = rf_val;
    end else if (rob_done) begin
      op.value = rob_val;
    end else if (cdb.valid && cdb.tag == tag) begin
      op.value = cdb.value;
    end else begin
      op.value = '0;
      op.ready = 1'b0;
    end
    return op;
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign imm    = word_t'($signed(i_inst[31:20]));
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  always_comb begin
    cls = CL_NOP;
    if (opcode == OPC_OPIMM) begin
      cls = CL_ALU;
    end else if (opcode == OPC_OP) begin
      if (funct7 == 7'b0000001) begin
        cls = (funct3 == 3'b000) ? CL_MUL : CL_NOP;  // rest of the M set is a nop
      end else if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
        cls = CL_ALU;
      end
    end
  end

  // immediate forms only use bit 30 for srai
  assign alt = funct7[5] && (opcode == OPC_OP || funct3 == 3'b101);

  always_comb begin
    case (funct3)
      3'b000:  o_alu_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  o_alu_op = ALU_SLL;
      3'b010:  o_alu_op = ALU_SLT;
      3'b011:  o_alu_op = ALU_SLTU;
      3'b100:  o_alu_op = ALU_XOR;
      3'b101:  o_alu_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  o_alu_op = ALU_OR;
      default: o_alu_op = ALU_AND;
    endcase
  end

  always_comb begin
    opnd_a = resolve(i_rf_busy1, i_rf_tag1, i_rf_val1, i_rob_done1, i_rob_val1, i_cdb);
    opnd_b = resolve(i_rf_busy2, i_rf_tag2, i_rf_val2, i_rob_done2, i_rob_val2, i_cdb);
    if (opcode == OPC_OPIMM) begin
      opnd_b.value = imm;
      opnd_b.ready = 1'b1;
    end
  end

  always_comb begin
    case (cls)
      CL_ALU:  o_inst_ready = !i_rob_full && i_alu_free;
      CL_MUL:  o_inst_ready = !i_rob_full && i_mul_free;
      default: o_inst_ready = 1'b1;  // nops are just dropped
    endcase
  end

  assign accept     = i_inst_valid && o_inst_ready;
  assign o_alloc    = accept && (cls != CL_NOP);  // also the rename strobe
  assign o_alu_push = accept && (cls == CL_ALU);
  assign o_mul_push = accept && (cls == CL_MUL);
  assign o_entry    = {i_rob_tail, opnd_a, opnd_b};

endmodule

`default_nettype wire

// File: source/pipelined_multiplier.sv
`timescale 1ns/10ps
`default_nettype none
`include "tomasulo_settings.svh"

module pipelined_multiplier (
  input  wire                         clk_100mhz,
  input  wire                         sys_rst,
  input  wire                         i_issue,
  input  wire tomasulo_pkg::word_t    i_a, i_b,
  input  wire tomasulo_pkg::rob_idx_t i_tag,
  output logic                        o_accept,
  output logic                        o_result_valid,
  output tomasulo_pkg::word_t         o_result,
  output tomasulo_pkg::rob_idx_t      o_tag,
  input  wire                         i_grant
);
  import tomasulo_pkg::*;

  localparam int S = `MUL_STAGES;

  logic     vld   [S];
  rob_idx_t tag_q [S];
  word_t    prod  [S];
  logic [S-1:0] take;  // stage can load this cycle

  // a stage moves when empty or when everything below it moves
  always_comb begin
    take[S-1] = !vld[S-1] || i_grant;
    for (int i = S - 2; i >= 0; i--) begin
      take[i] = !vld[i] || take[i+1];
    end
  end

  assign o_accept       = take[0];
  assign o_result_valid = vld[S-1];
  assign o_result       = prod[S-1];
  assign o_tag          = tag_q[S-1];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < S; i++) begin
        vld[i] <= 1'b0;
      end
    end else begin
      if (take[0]) begin
        vld[0] <= i_issue;
      end
      for (int i = 1; i < S; i++) begin
        if (take[i]) begin
          vld[i] <= vld[i-1];
        end
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (take[0]) begin
      prod[0]  <= i_a * i_b;  // low word of the product
      tag_q[0] <= i_tag;
    end
    for (int i = 1; i < S; i++) begin
      if (take[i]) begin
        prod[i]  <= prod[i-1];
        tag_q[i] <= tag_q[i-1];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rename_regfile.sv
`timescale 1ns/10ps
`default_nettype none
`include "tomasulo_settings.svh"

module rename_regfile (
  input  wire                         clk_100mhz,
  input  wire                         sys_rst,
  input  wire tomasulo_pkg::reg_idx_t i_rs1, i_rs2,
  output logic                        o_busy1, o_busy2,
  output tomasulo_pkg::rob_idx_t      o_tag1, o_tag2,
  output tomasulo_pkg::word_t         o_val1, o_val2,
  input  wire                         i_rename,
  input  wire tomasulo_pkg::reg_idx_t i_rename_rd,
  input  wire tomasulo_pkg::rob_idx_t i_rename_tag,
  input  wire tomasulo_pkg::commit_t  i_commit,
  input  wire tomasulo_pkg::rob_idx_t i_commit_tag
);
  import tomasulo_pkg::*;

  word_t    regs [`NUM_REGS];
  logic     busy [`NUM_REGS];
  rob_idx_t tags [`NUM_REGS];  // youngest writer in flight

  assign o_busy1 = busy[i_rs1];
  assign o_busy2 = busy[i_rs2];
  assign o_tag1  = tags[i_rs1];
  assign o_tag2  = tags[i_rs2];
  assign o_val1  = regs[i_rs1];
  assign o_val2  = regs[i_rs2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
        busy[i] <= 1'b0;
        tags[i] <= '0;
      end
    end else begin
      if (i_commit.valid && i_commit.rd != '0) begin
        regs[i_commit.rd] <= i_commit.value;
        if (tags[i_commit.rd] == i_commit_tag) begin
          busy[i_commit.rd] <= 1'b0;  // no younger writer left
        end
      end
      // same-cycle rename overrides the clear above
      if (i_rename && i_rename_rd != '0) begin
        busy[i_rename_rd] <= 1'b1;
        tags[i_rename_rd] <= i_rename_tag;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none
`include "tomasulo_settings.svh"

module reorder_buffer (
  input  wire                         clk_100mhz,
  input  wire                         sys_rst,
  input  wire                         i_alloc,
  input  wire tomasulo_pkg::reg_idx_t i_rd,
  output tomasulo_pkg::rob_idx_t      o_tail,
  output logic                        o_full,
  input  wire tomasulo_pkg::cdb_t     i_cdb,
  input  wire tomasulo_pkg::rob_idx_t i_tag1, i_tag2,
  output logic                        o_done1, o_done2,
  output tomasulo_pkg::word_t         o_val1, o_val2,
  output tomasulo_pkg::commit_t       o_commit,
  output tomasulo_pkg::rob_idx_t      o_commit_tag
);
  import tomasulo_pkg::*;

  localparam int CW = $clog2(`ROB_SIZE) + 1;

  reg_idx_t      rd_q   [`ROB_SIZE];
  word_t         val_q  [`ROB_SIZE];
  logic          done_q [`ROB_SIZE];
  rob_idx_t      head;
  rob_idx_t      tail;
  logic [CW-1:0] count;
  logic          retire;

  assign o_tail  = tail;
  assign o_full  = (count == CW'(`ROB_SIZE));
  assign o_done1 = done_q[i_tag1];
  assign o_done2 = done_q[i_tag2];
  assign o_val1  = val_q[i_tag1];
  assign o_val2  = val_q[i_tag2];

  // head retires once its result is in
  assign retire         = (count != '0) && done_q[head];
  assign o_commit.valid = retire;
  assign o_commit.rd    = rd_q[head];
  assign o_commit.value = val_q[head];
  assign o_commit_tag   = head;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < `ROB_SIZE; i++) begin
        done_q[i] <= 1'b0;
      end
    end else begin
      if (i_alloc) begin
        done_q[tail] <= 1'b0;
        tail         <= tail + 1'b1;  // wraps at the power of two
      end
      if (i_cdb.valid) begin
        done_q[i_cdb.tag] <= 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
      count <= count + CW'(i_alloc) - CW'(retire);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc) begin
      rd_q[tail] <= i_rd;
    end
    if (i_cdb.valid) begin
      val_q[i_cdb.tag] <= i_cdb.value;
    end
  end

endmodule

`default_nettype wire

// File: source/reservation_station.sv
`timescale 1ns/10ps
`default_nettype none
`include "tomasulo_settings.svh"

module reservation_station #(
  parameter type op_t = logic
) (
  input  wire                        clk_100mhz,
  input  wire                        sys_rst,
  input  wire                        i_push,
  input  wire tomasulo_pkg::issue_t  i_entry,
  input  wire op_t                   i_op,
  output logic                       o_free,
  input  wire tomasulo_pkg::cdb_t    i_cdb,
  input  wire                        i_accept,
  output logic                       o_issue,
  output tomasulo_pkg::word_t        o_a, o_b,
  output op_t                        o_op,
  output tomasulo_pkg::rob_idx_t     o_tag
);
  import tomasulo_pkg::*;

  localparam int IW = $clog2(`RS_DEPTH);

  logic          valid [`RS_DEPTH];
  issue_t        ent   [`RS_DEPTH];
  op_t           ops   [`RS_DEPTH];
  logic [IW-1:0] free_idx;
  logic [IW-1:0] rdy_idx;
  logic          rdy_found;

  // scan downwards so the lowest index ends up selected
  always_comb begin
    o_free    = 1'b0;
    free_idx  = '0;
    rdy_found = 1'b0;
    rdy_idx   = '0;
    for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        o_free   = 1'b1;
        free_idx = IW'(i);
      end
      if (valid[i] && ent[i].a.ready && ent[i].b.ready) begin
        rdy_found = 1'b1;
        rdy_idx   = IW'(i);
      end
    end
  end

  assign o_issue = rdy_found && i_accept;
  assign o_a     = ent[rdy_idx].a.value;
  assign o_b     = ent[rdy_idx].b.value;
  assign o_op    = ops[rdy_idx];
  assign o_tag   = ent[rdy_idx].tag;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < `RS_DEPTH; i++) begin
        valid[i] <= 1'b0;
      end
    end else begin
      if (o_issue) begin
        valid[rdy_idx] <= 1'b0;
      end
      if (i_push && o_free) begin
        valid[free_idx] <= 1'b1;  // never the slot leaving above
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < `RS_DEPTH; i++) begin
      if (valid[i] && i_cdb.valid) begin
        if (!ent[i].a.ready && ent[i].a.tag == i_cdb.tag) begin
          ent[i].a.value <= i_cdb.value;
          ent[i].a.ready <= 1'b1;
        end
        if (!ent[i].b.ready && ent[i].b.tag == i_cdb.tag) begin
          ent[i].b.value <= i_cdb.value;
          ent[i].b.ready <= 1'b1;
        end
      end
    end
    if (i_push && o_free) begin
      ent[free_idx] <= i_entry;
      ops[free_idx] <= i_op;
    end
  end

endmodule

`default_nettype wire

// File: source/tomasulo_core.sv
`timescale 1ns/10ps
`default_nettype none

module tomasulo_core (
  input  wire                      clk_100mhz,
  input  wire                      sys_rst,
  input  wire                      i_inst_valid,
  input  wire tomasulo_pkg::word_t i_inst,
  output logic                     o_inst_ready,
  output tomasulo_pkg::commit_t    o_commit
);
  import tomasulo_pkg::*;

  // decode and rename
  reg_idx_t rs1, rs2, rd;
  logic     rf_busy1, rf_busy2;
  rob_idx_t rf_tag1, rf_tag2;
  word_t    rf_val1, rf_val2;
  logic     rob_done1, rob_done2;
  word_t    rob_val1, rob_val2;
  logic     rob_full, alloc;
  rob_idx_t rob_tail, commit_tag;

  // station inputs and outputs
  issue_t   entry;
  alu_op_t  alu_op, ex_alu_op;
  logic     alu_push, mul_push;
  logic     alu_free, mul_free;
  logic     alu_issue, mul_issue;
  word_t    alu_a, alu_b, mul_a, mul_b;
  rob_idx_t alu_tag_in, mul_tag_in;

  // units and the bus
  logic     alu_accept, mul_accept;
  logic     alu_valid, mul_valid;
  logic     alu_grant, mul_grant;
  word_t    alu_result, mul_result;
  rob_idx_t alu_tag, mul_tag;
  cdb_t     cdb;

  issue_unit u_issue (
    .i_inst_valid(i_inst_valid), .i_inst(i_inst), .o_inst_ready(o_inst_ready),
    .o_rs1(rs1), .o_rs2(rs2),
    .i_rf_busy1(rf_busy1), .i_rf_busy2(rf_busy2),
    .i_rf_tag1(rf_tag1), .i_rf_tag2(rf_tag2),
    .i_rf_val1(rf_val1), .i_rf_val2(rf_val2),
    .i_rob_done1(rob_done1), .i_rob_done2(rob_done2),
    .i_rob_val1(rob_val1), .i_rob_val2(rob_val2),
    .i_rob_full(rob_full), .i_rob_tail(rob_tail),
    .o_alloc(alloc), .o_rd(rd),
    .i_cdb(cdb),
    .i_alu_free(alu_free), .i_mul_free(mul_free),
    .o_alu_push(alu_push), .o_mul_push(mul_push),
    .o_entry(entry), .o_alu_op(alu_op)
  );

  rename_regfile u_regfile (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_rs1(rs1), .i_rs2(rs2),
    .o_busy1(rf_busy1), .o_busy2(rf_busy2),
    .o_tag1(rf_tag1), .o_tag2(rf_tag2),
    .o_val1(rf_val1), .o_val2(rf_val2),
    .i_rename(alloc), .i_rename_rd(rd), .i_rename_tag(rob_tail),
    .i_commit(o_commit), .i_commit_tag(commit_tag)
  );

  // rob is read with the tags the register file hands out
  reorder_buffer u_rob (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_alloc(alloc), .i_rd(rd),
    .o_tail(rob_tail), .o_full(rob_full),
    .i_cdb(cdb),
    .i_tag1(rf_tag1), .i_tag2(rf_tag2),
    .o_done1(rob_done1), .o_done2(rob_done2),
    .o_val1(rob_val1), .o_val2(rob_val2),
    .o_commit(o_commit), .o_commit_tag(commit_tag)
  );

  reservation_station #(.op_t(alu_op_t)) rs_alu (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_push(alu_push), .i_entry(entry), .i_op(alu_op),
    .o_free(alu_free), .i_cdb(cdb), .i_accept(alu_accept),
    .o_issue(alu_issue), .o_a(alu_a), .o_b(alu_b),
    .o_op(ex_alu_op), .o_tag(alu_tag_in)
  );

  // mul payload is constant, nothing downstream reads it
  reservation_station #(.op_t(mul_op_t)) rs_mul (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_push(mul_push), .i_entry(entry), .i_op(MUL_MUL),
    .o_free(mul_free), .i_cdb(cdb), .i_accept(mul_accept),
    .o_issue(mul_issue), .o_a(mul_a), .o_b(mul_b),
    .o_op(), .o_tag(mul_tag_in)
  );

  alu_unit u_alu (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_issue(alu_issue), .i_a(alu_a), .i_b(alu_b),
    .i_op(ex_alu_op), .i_tag(alu_tag_in),
    .o_accept(alu_accept), .o_result_valid(alu_valid),
    .o_result(alu_result), .o_tag(alu_tag),
    .i_grant(alu_grant)
  );

  pipelined_multiplier u_mul (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_issue(mul_issue), .i_a(mul_a), .i_b(mul_b), .i_tag(mul_tag_in),
    .o_accept(mul_accept), .o_result_valid(mul_valid),
    .o_result(mul_result), .o_tag(mul_tag),
    .i_grant(mul_grant)
  );

  cdb_arbiter u_cdb (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_mul_valid(mul_valid), .i_mul_result(mul_result), .i_mul_tag(mul_tag),
    .i_alu_valid(alu_valid), .i_alu_result(alu_result), .i_alu_tag(alu_tag),
    .o_mul_grant(mul_grant), .o_alu_grant(alu_grant),
    .o_cdb(cdb)
  );

endmodule

`default_nettype wire

// File: source/tomasulo_pkg.sv
`default_nettype none
`include "tomasulo_settings.svh"

package tomasulo_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_t;

  // single function, gives the mul station a payload of its own
  typedef enum logic [0:0] {
    MUL_MUL
  } mul_op_t;

  // ready operand holds its value, a waiting one its tag
  typedef struct packed {
    word_t    value;
    logic     ready;
    rob_idx_t tag;
  } operand_t;

  typedef struct packed {
    logic     valid;
    rob_idx_t tag;
    word_t    value;
  } cdb_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    value;
  } commit_t;

  typedef struct packed {
    rob_idx_t tag;  // rob entry the result goes to
    operand_t a;
    operand_t b;
  } issue_t;

endpackage

`default_nettype wire

// File: testbench/tb_tomasulo_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tomasulo_core;
  import tomasulo_pkg::*;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] value;
  } expect_t;

  logic        clk_100mhz;
  logic        sys_rst;
  logic        i_inst_valid;
  logic [31:0] i_inst;
  logic        o_inst_ready;
  commit_t     o_commit;

  logic [31:0] model_regs [32];  // in-order architectural state
  expect_t     exp_q [$];        // commits still owed in issue order
  integer      seed = 32'h5e8;
  logic        stall_seen;

  tomasulo_core uut (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst),
    .o_inst_ready(o_inst_ready), .o_commit(o_commit)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  task automatic report_fail();
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
      report_fail();
    end
  endtask

  // RV32 semantics of OP, OPIMM and MUL
  function automatic logic [31:0] ref_exec(input logic is_mul, input logic [2:0] f3,
                                           input logic alt, input logic [31:0] a,
                                           input logic [31:0] b);
    logic [31:0]        prod;
    logic signed [31:0] sra;
    prod = a * b;  // low word only
    sra  = $signed(a) >>> b[4:0];
    if (is_mul) begin
      return prod;
    end
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? sra : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  // {funct7, funct3} of the ten ALU functions
  function automatic logic [9:0] op_code(input int k);
    case (k)
      0:       return {7'h00, 3'b000};
      1:       return {7'h20, 3'b000};
      2:       return {7'h00, 3'b111};
      3:       return {7'h00, 3'b110};
      4:       return {7'h00, 3'b100};
      5:       return {7'h00, 3'b010};
      6:       return {7'h00, 3'b011};
      7:       return {7'h00, 3'b001};
      8:       return {7'h00, 3'b101};
      default: return {7'h20, 3'b101};
    endcase
  endfunction

  // hold valid until the core takes it, then log what should commit
  task automatic issue_inst(input logic [31:0] inst);
    logic        is_imm;
    logic        is_mul;
    logic        is_op;
    logic        alt;
    logic [31:0] b;
    expect_t     e;
    int          waited;
    is_imm = inst[6:0] == 7'b0010011;
    is_op  = inst[6:0] == 7'b0110011 && (inst[31:25] == 7'h00 || inst[31:25] == 7'h20);
    is_mul = inst[6:0] == 7'b0110011 && inst[31:25] == 7'h01 && inst[14:12] == 3'b000;
    alt    = inst[30] && (!is_imm || inst[14:12] == 3'b101);
    i_inst_valid = 1'b1;
    i_inst       = inst;
    waited       = 0;
    @(negedge clk_100mhz);
    while (!o_inst_ready) begin
      stall_seen = 1'b1;
      waited++;
      if (waited > 200) begin
        $display("timeout: instruction %08h was never accepted", inst);
        report_fail();
      end else begin
        @(negedge clk_100mhz);
      end
    end
    if (is_imm || is_op || is_mul) begin
      b       = is_imm ? {{20{inst[31]}}, inst[31:20]} : model_regs[inst[24:20]];
      e.rd    = inst[11:7];
      e.value = ref_exec(is_mul, inst[14:12], alt, model_regs[inst[19:15]], b);
      exp_q.push_back(e);
      if (e.rd != 5'd0) begin
        model_regs[e.rd] = e.value;  // x0 stays zero
      end
    end
    @(posedge clk_100mhz);
    #1;
    i_inst_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > 500) begin
        $display("timeout: %0d commits never arrived", exp_q.size());
        report_fail();
      end else begin
        @(negedge clk_100mhz);
      end
    end
    repeat (5) @(posedge clk_100mhz);  // room for a stray commit
    #1;
  endtask

  task automatic sweep_alu();
    logic [9:0] fn;
    for (int k = 0; k < 10; k++) begin
      fn = op_code(k);
      for (int p = 1; p <= 5; p++) begin
        issue_inst(enc_r(fn[9:3], 5'(p), 5'(p % 5 + 1), fn[2:0], 5'(10 + p)));
      end
    end
    // immediate forms with edge immediates and shift amounts
    for (int p = 1; p <= 3; p++) begin
      issue_inst(enc_i(12'h7ff, 5'(p), 3'b000, 5'd16));
      issue_inst(enc_i(12'h800, 5'(p), 3'b010, 5'd17));
      issue_inst(enc_i(12'hfff, 5'(p), 3'b011, 5'd18));
      issue_inst(enc_i(12'h800, 5'(p), 3'b100, 5'd19));
      issue_inst(enc_i(12'h7ff, 5'(p), 3'b110, 5'd20));
      issue_inst(enc_i(12'hfff, 5'(p), 3'b111, 5'd21));
      issue_inst(enc_i(12'd31, 5'(p), 3'b001, 5'd22));
      issue_inst(enc_i(12'd1, 5'(p), 3'b101, 5'd23));
      issue_inst(enc_i(12'h41f, 5'(p), 3'b101, 5'd24));  // srai by 31
    end
  endtask

  task automatic random_program(input int n);
    logic [31:0] r;
    logic [9:0]  fn;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    for (int i = 0; i < n; i++) begin
      r   = $random(seed);
      rd  = {1'b0, r[3:0]};  // only x0 to x15 for frequent hazards
      rs1 = {1'b0, r[7:4]};
      rs2 = {1'b0, r[11:8]};
      fn  = op_code(int'(r[19:16]) % 10);
      case (r[14:12])
        3'd0: issue_inst(r[15] ? {r[31:12], rd, 7'b0110111} : enc_r(7'h01, rs2, rs1, 3'b100, rd));
        3'd1, 3'd2: issue_inst(enc_r(7'h01, rs2, rs1, 3'b000, rd));
        3'd3, 3'd4: issue_inst(enc_r(fn[9:3], rs2, rs1, fn[2:0], rd));
        default: begin
          if (r[18:16] == 3'b001) begin
            issue_inst(enc_i({7'h00, r[24:20]}, rs1, 3'b001, rd));
          end else if (r[18:16] == 3'b101) begin
            issue_inst(enc_i({1'b0, r[25], 5'h00, r[24:20]}, rs1, 3'b101, rd));
          end else begin
            issue_inst(enc_i(r[31:20], rs1, r[18:16], rd));
          end
        end
      endcase
    end
  endtask

  initial begin : commit_checker
    expect_t e;
    forever begin
      @(negedge clk_100mhz);
      if (!sys_rst && o_commit.valid) begin
        if (exp_q.size() == 0) begin
          $display("commit to x%0d with no instruction outstanding", o_commit.rd);
          report_fail();
        end else begin
          e = exp_q.pop_front();
          check_eq("o_commit.rd", 32'(o_commit.rd), 32'(e.rd));
          check_eq("o_commit.value", o_commit.value, e.value);
        end
      end
    end
  end

  initial begin
    sys_rst      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = 32'h0;
    stall_seen   = 1'b0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = 32'h0;
    end
    repeat (10) @(posedge clk_100mhz);
    #1;
    sys_rst = 1'b0;
    i_inst  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);  // shown, never valid
    repeat (5) begin
      @(negedge clk_100mhz);
      check_eq("o_inst_ready", 32'(o_inst_ready), 32'd1);
      check_eq("o_commit.valid", 32'(o_commit.valid), 32'd0);
    end
    @(posedge clk_100mhz);
    #1;
    // edge values -1, 0x80000000, 0x7fffffff, 5 and -2048
    issue_inst(enc_i(12'hfff, 5'd0, 3'b000, 5'd1));
    issue_inst(enc_i(12'd1, 5'd0, 3'b000, 5'd2));
    issue_inst(enc_i(12'd31, 5'd2, 3'b001, 5'd2));
    issue_inst(enc_i(12'd1, 5'd1, 3'b101, 5'd3));
    issue_inst(enc_i(12'd5, 5'd0, 3'b000, 5'd4));
    issue_inst(enc_i(12'h800, 5'd0, 3'b000, 5'd5));
    sweep_alu();
    wait_drain();
    // dependent chain through x6
    for (int k = 0; k < 12; k++) begin
      issue_inst(enc_r(op_code(k % 10) >> 3, 5'd4, 5'd6, 3'(op_code(k % 10)), 5'd6));
      issue_inst(enc_i(12'(k * 37 + 1), 5'd6, 3'b000, 5'd6));
    end
    wait_drain();
    // mul next to alu work with x0 written then read
    for (int k = 0; k < 3; k++) begin
      issue_inst(enc_r(7'h01, 5'd3, 5'd1, 3'b000, 5'd7));
      issue_inst(enc_r(7'h00, 5'd2, 5'd4, 3'b000, 5'd8));
      issue_inst(enc_r(7'h01, 5'd7, 5'd4, 3'b000, 5'd9));
      issue_inst(enc_r(7'h01, 5'd3, 5'd3, 3'b000, 5'd0));
      issue_inst(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd10));
      issue_inst(enc_i(12'd9, 5'd0, 3'b110, 5'd0));
      issue_inst(enc_r(7'h00, 5'd0, 5'd9, 3'b110, 5'd13));
    end
    wait_drain();
    // dependent mul burst should back up the station
    issue_inst(enc_i(12'd7, 5'd0, 3'b000, 5'd11));
    issue_inst(enc_i(12'd3, 5'd0, 3'b000, 5'd12));
    stall_seen = 1'b0;
    for (int k = 0; k < 12; k++) begin
      issue_inst(enc_r(7'h01, 5'd12, 5'd11, 3'b000, 5'd11));
    end
    if (!stall_seen) begin
      $display("o_inst_ready never went low during the multiply burst");
      report_fail();
    end
    wait_drain();
    random_program(200);
    wait_drain();
    if (exp_q.size() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tomasulo_core.f
+incdir+include
source/tomasulo_pkg.sv
source/issue_unit.sv
source/rename_regfile.sv
source/reorder_buffer.sv
source/reservation_station.sv
source/alu_unit.sv
source/pipelined_multiplier.sv
source/cdb_arbiter.sv
source/tomasulo_core.sv
testbench/tb_tomasulo_core.sv
